/* obj_line_engine.f */
hdl/obj_pkg.sv
hdl/rom_pkg.sv
hdl/obj_frame_ram.sv
hdl/gfx_bank_mapper.sv
hdl/obj_tile_match.sv
hdl/obj_line_scan.sv
hdl/obj_tile_draw.sv
hdl/obj_line_engine.sv
tb/obj_line_engine_tb.sv

/* Bender.yml */
package:
  name: obj_line_engine

sources:
  - hdl/obj_pkg.sv
  - hdl/rom_pkg.sv
  - hdl/obj_frame_ram.sv
  - hdl/gfx_bank_mapper.sv
  - hdl/obj_tile_match.sv
  - hdl/obj_line_scan.sv
  - hdl/obj_tile_draw.sv
  - hdl/obj_line_engine.sv
  - target: test
    files:
      - tb/obj_line_engine_tb.sv

/* tb/obj_line_engine_tb.sv */
// object line engine testbench
module obj_line_engine_tb
    import obj_pkg::*, rom_pkg::*;
();

    localparam int FRAME_AW    = 6;
    localparam int DRAW_CYCLES = 8;
    localparam int NUM_CASES   = 6;
    localparam int WAIT_LIMIT  = 2000;   // cycles per wait

    typedef struct packed {
        obj_word_t x;
        obj_word_t y;
        obj_code_t code;
        obj_attr_t attr;
    } entry_t;

    typedef struct packed {
        entry_t [0:3] ent;       // frame entries 0..3, the rest random
        bank_cfg_t    bank;
        logic         flip;
        obj_vpos_t    vrender;
        logic [7:0]   n_draw;    // expected record count
    } case_t;

    // entry words are x_y_code_attr
    case_t cases [NUM_CASES] = '{
        '{'{64'h01F8_0078_0120_0003, 64'h0030_0081_0140_0005,   // single tiles
            64'h0050_0071_0160_0007, 64'h0090_FE70_0180_0009},
          {6'h00, 16'h0002, 16'h000F}, 1'b0, 9'h080, 8'd2},
        '{'{64'h0020_0090_2300_126A, 64'h0100_00A0_4510_2101,   // multi tile with flips
            64'h01F0_0095_6000_1122, 64'h0000_0000_7000_0000},
          {6'h00, 16'h0000, 16'hFFFF}, 1'b0, 9'h0A5, 8'd7},
        '{'{64'h0010_0040_2345_0001, 64'h0020_0040_6345_0002,   // game index 2, range 5
            64'h0030_0040_4345_0003, 64'h0040_0040_3012_0004},
          {6'h16, 16'hA8C1, 16'h7354}, 1'b0, 9'h040, 8'd2},
        '{'{64'h0010_01C0_F111_0001, 64'h0020_01B8_C222_0002,   // game index 1, no range
            64'h0030_01C0_8333_0003, 64'h0040_01C0_1444_0004},
          {6'h01, 16'h3132, 16'h0FC0}, 1'b0, 9'h1C0, 8'd2},
        '{'{64'h0040_0030_0500_0001, 64'h0060_0030_0600_0002,   // repeated entries
            64'h0040_0030_0500_0001, 64'h0040_0030_0500_0001},
          {6'h03, 16'h5000, 16'hF000}, 1'b0, 9'h030, 8'd3},
        '{'{64'h01F8_0078_0120_0003, 64'h0030_0081_0140_0005,   // first table, flipped
            64'h0050_0071_0160_0007, 64'h0090_FE70_0180_0009},
          {6'h00, 16'h0002, 16'h000F}, 1'b1, 9'h087, 8'd3}
    };

    logic                clk = 1'b0;
    logic                rst;
    logic                frame_we;
    logic [FRAME_AW-1:0] frame_waddr;
    obj_word_t           frame_wdata;
    logic                flip;
    obj_vpos_t           vrender;
    logic                start;
    bank_cfg_t           bank;
    logic                draw_valid;
    obj_draw_t           draw;
    logic                scan_busy;

    entry_t    frame [16];           // table image for the model
    obj_draw_t exp_q [$];
    obj_draw_t got_q [$];
    int        cycle_cnt = 0;
    int        last_draw = -1000;    // cycle of the previous draw_valid

    obj_line_engine #(.FRAME_AW(FRAME_AW), .DRAW_CYCLES(DRAW_CYCLES)) dut (.*);

    always #2 clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %0h, expected %0h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // collect records, renderer busy time sets the minimum gap
    always @(posedge clk) begin
        cycle_cnt++;
        if (draw_valid) begin
            check("draw_valid gap ok", (cycle_cnt - last_draw) >= DRAW_CYCLES, 1);
            got_q.push_back(draw);
            last_draw = cycle_cnt;
        end
    end

    // scan rules applied to the table image, top entry first
    task automatic build_expected(input case_t c);
        obj_vpos_t vf;
        obj_vpos_t d;
        entry_t    e;
        entry_t    last;
        logic      have_last;
        bank_nib_t top;
        obj_code_t mcode;
        tile_idx_t m;
        tile_idx_t row;
        tile_idx_t vsub;
        int        col;
        obj_draw_t rec;
        vf        = c.vrender ^ {1'b0, {8{c.flip}}};
        have_last = 1'b0;
        last      = '0;
        exp_q.delete();
        for (int k = 15; k >= 0; k--) begin
            e   = frame[k];
            top = e.code[15:12];
            if (c.bank.game[5:2] != 4'd0 && top > c.bank.game[5:2]) continue;   // unmapped
            if ((top & ~c.bank.mask[c.bank.game[1:0]]) != 4'd0) continue;         // outside mask
            mcode = {(top & c.bank.mask[c.bank.game[1:0]]) | c.bank.offset[c.bank.game[1:0]],
                     e.code[11:0]};
            m = e.attr[15:12];
            d = vf - e.y[8:0];                                // wraps at 512
            if (int'(d) >= 16 * (int'(m) + 1)) continue;      // not on this line
            if (have_last && e.x[8:0] == last.x[8:0] && e.y[8:0] == last.y[8:0] &&
                e.code == last.code && e.attr == last.attr) continue;
            have_last = 1'b1;
            last      = e;
            row       = tile_idx_t'(d / 16);
            vsub      = tile_idx_t'(d % 16);
            if (e.attr[6]) begin   // vflip
                row  = m - row;
                vsub = 4'd15 - vsub;
            end
            for (int j = 0; j <= int'(e.attr[11:8]); j++) begin
                col       = e.attr[5] ? int'(e.attr[11:8]) - j : j;   // hflip reverses
                rec.code  = {mcode[15:8], 4'(mcode[7:4] + row), 4'(mcode[3:0] + j)};
                rec.vsub  = vsub;
                rec.hflip = e.attr[5];
                rec.pal   = e.attr[4:0];
                rec.hpos  = e.x[8:0] + obj_hpos_t'(16 * col);
                exp_q.push_back(rec);
            end
        end
    endtask

    task automatic run_case(input case_t c);
        obj_vpos_t vf;
        obj_vpos_t gap;
        int        t;
        vf = c.vrender ^ {1'b0, {8{c.flip}}};
        for (int k = 0; k < 16; k++) begin
            if (k < 4) begin
                frame[k] = c.ent[k];
            end else begin
                gap           = 9'd256 + 9'($urandom % 256);   // taller than any object
                frame[k].x    = 16'($urandom);
                frame[k].y    = {7'($urandom), 9'(vf - gap)};
                frame[k].code = 16'($urandom);
                frame[k].attr = 16'($urandom);
            end
        end
        for (int a = 0; a < 64; a++) begin
            @(posedge clk);
            frame_we    <= 1'b1;
            frame_waddr <= 6'(a);
            frame_wdata <= frame[a / 4][63 - 16 * (a % 4) -: 16];   // x, y, code, attr
        end
        build_expected(c);
        got_q.delete();
        @(posedge clk);
        frame_we <= 1'b0;
        bank     <= c.bank;
        flip     <= c.flip;
        vrender  <= c.vrender;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        t = 0;
        @(posedge clk);
        while (scan_busy) begin
            if (t == WAIT_LIMIT) timeout_fail("scan_busy to fall");
            t++;
            @(posedge clk);
        end
        t = 0;
        while (!dut.idle) begin   // last tile still drawing
            if (t == WAIT_LIMIT) timeout_fail("draw engine idle");
            t++;
            @(posedge clk);
        end
        check("scan_busy", scan_busy, 0);
        check("draw count", got_q.size(), exp_q.size());
        check("table draw count", exp_q.size(), c.n_draw);
        foreach (got_q[i]) begin
            check("draw.code", got_q[i].code, exp_q[i].code);
            check("draw.vsub", got_q[i].vsub, exp_q[i].vsub);
            check("draw.hflip", got_q[i].hflip, exp_q[i].hflip);
            check("draw.pal", got_q[i].pal, exp_q[i].pal);
            check("draw.hpos", got_q[i].hpos, exp_q[i].hpos);
        end
    endtask

    initial begin
        void'($urandom(32'h0386735d));
        rst         = 1'b1;
        frame_we    = 1'b0;
        frame_waddr = '0;
        frame_wdata = '0;
        flip        = 1'b0;
        vrender     = '0;
        start       = 1'b0;
        bank        = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("scan_busy", scan_busy, 0);
        check("draw_valid", draw_valid, 0);
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(cases[i]);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* hdl/obj_line_engine.sv */
// object line engine top
module obj_line_engine import obj_pkg::*, rom_pkg::*; #(
    parameter int FRAME_AW    = 10,
    parameter int DRAW_CYCLES = 8
) (
    input  logic                clk,
    input  logic                rst,
    // cpu writes to the frame table
    input  logic                frame_we,
    input  logic [FRAME_AW-1:0] frame_waddr,
    input  obj_word_t           frame_wdata,
    // line control
    input  logic                flip,
    input  obj_vpos_t           vrender,
    input  logic                start,
    input  bank_cfg_t           bank,
    // renderer output
    output logic                draw_valid,
    output obj_draw_t           draw,
    output logic                scan_busy
);

    logic [FRAME_AW-1:0] frame_addr;
    obj_word_t           frame_data;
    logic                cmd_start;
    obj_cmd_t            cmd;
    logic                idle;

    obj_frame_ram #(.FRAME_AW(FRAME_AW)) u_frame (
        .clk  (clk),
        .we   (frame_we),
        .waddr(frame_waddr),
        .wdata(frame_wdata),
        .raddr(frame_addr),
        .rdata(frame_data)
    );

    obj_line_scan #(.FRAME_AW(FRAME_AW)) u_scan (
        .clk       (clk),
        .rst       (rst),
        .flip      (flip),
        .vrender   (vrender),
        .start     (start),
        .bank      (bank),
        .frame_addr(frame_addr),
        .frame_data(frame_data),
        .idle      (idle),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .busy      (scan_busy)
    );

    obj_tile_draw #(.DRAW_CYCLES(DRAW_CYCLES)) u_draw (
        .clk       (clk),
        .rst       (rst),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .idle      (idle),
        .draw_valid(draw_valid),
        .draw      (draw)
    );

endmodule

/* hdl/obj_tile_draw.sv */
// tile draw engine model
module obj_tile_draw import obj_pkg::*; #(
    parameter int DRAW_CYCLES = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_start,
    input  obj_cmd_t  cmd,
    output logic      idle,
    output logic      draw_valid,
    output obj_draw_t draw
);

    localparam int CW = $clog2(DRAW_CYCLES + 1);

    logic [CW-1:0] busy_cnt;   // cycles left before idle
    logic          accept;

    assign accept = cmd_start && idle;   // ignore strobes while drawing

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idle       <= 1'b1;
            busy_cnt   <= '0;
            draw_valid <= 1'b0;
        end else begin
            draw_valid <= accept;   // one pulse per tile
            if (accept) begin
                idle     <= 1'b0;
                busy_cnt <= CW'(DRAW_CYCLES - 1);
            end else if (!idle) begin
                if (busy_cnt == '0) begin
                    idle <= 1'b1;   // DRAW_CYCLES after cmd_start
                end else begin
                    busy_cnt <= busy_cnt - 1'b1;
                end
            end
        end
    end

    // draw record
    always_ff @(posedge clk) begin
        if (accept) begin
            draw.code  <= cmd.code;
            draw.vsub  <= cmd.attr[11:8];       // in-tile row
            draw.hflip <= attr_hflip(cmd.attr);
            draw.pal   <= attr_pal(cmd.attr);
            draw.hpos  <= cmd.hpos + 9'd1;      // back to the true left edge
        end
    end

endmodule

/* hdl/obj_line_scan.sv */
// object line scanner
module obj_line_scan import obj_pkg::*, rom_pkg::*; #(
    parameter int FRAME_AW = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flip,
    input  obj_vpos_t           vrender,      // one line ahead of display
    input  logic                start,
    input  bank_cfg_t           bank,
    // frame table, one cycle read
    output logic [FRAME_AW-1:0] frame_addr,
    input  obj_word_t           frame_data,
    // renderer
    input  logic                idle,
    output logic                cmd_start,
    output obj_cmd_t            cmd,
    output logic                busy
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_FETCH,      // table read latency
        S_ATTR,
        S_CODE,
        S_Y,
        S_X,
        S_MAP,        // bank mapping check
        S_ZONE,       // zone and repeat check
        S_CMD,
        S_CMD_END,
        S_TILE_WAIT   // let code_mn follow the tile counter
    } state_t;

    state_t    state;
    obj_vpos_t vf;
    obj_attr_t obj_attr;
    obj_code_t pre_code;    // raw code from the table
    obj_code_t obj_code;    // after bank mapping
    obj_vpos_t obj_y;
    obj_hpos_t obj_x;
    obj_attr_t last_attr;   // last accepted entry
    obj_code_t last_code;
    obj_vpos_t last_y;
    obj_hpos_t last_x;
    logic [9:0] cin;
    tile_idx_t n;           // tile counter
    tile_idx_t npos;        // column of the current tile
    logic      first;       // no entry accepted yet this line
    logic      last_entry;  // entry 0 being processed
    map_res_t  res;
    tile_idx_t vsub;
    logic      inzone;
    obj_code_t code_mn;
    logic      repeated;
    logic      drop_map;
    logic      accept_obj;
    obj_hpos_t eff_x;

    gfx_bank_mapper u_mapper (
        .clk (clk),
        .rst (rst),
        .bank(bank),
        .cin (cin),
        .res (res)
    );

    obj_tile_match u_match (
        .clk    (clk),
        .code   (obj_code),
        .attr   (obj_attr),
        .n      (n),
        .vf     (vf),
        .y      (obj_y),
        .vsub   (vsub),
        .inzone (inzone),
        .code_mn(code_mn)
    );

    assign repeated = (obj_attr == last_attr) && (pre_code == last_code) &&
                      (obj_y == last_y) && (obj_x == last_x);
    assign drop_map = res.unmapped || ((pre_code[15:12] & ~res.mask) != 4'd0);
    assign accept_obj = inzone && !(repeated && !first);

    assign eff_x = obj_x + {1'b0, npos, 4'd0};   // left edge of this column
    assign busy  = state != S_IDLE;

    // control path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            frame_addr <= '1;
            first      <= 1'b1;
            last_entry <= 1'b0;
            n          <= '0;
            npos       <= '0;
            cmd_start  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        frame_addr <= '1;   // attr of the top entry
                        first      <= 1'b1;
                        last_entry <= 1'b0;
                        state      <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    frame_addr <= frame_addr - 1'b1;
                    state      <= S_ATTR;
                end
                S_ATTR: begin
                    n          <= '0;
                    // hflip draws from the rightmost column
                    npos       <= attr_hflip(frame_data) ? attr_cols(frame_data) : 4'd0;
                    frame_addr <= frame_addr - 1'b1;
                    state      <= S_CODE;
                end
                S_CODE: begin
                    frame_addr <= frame_addr - 1'b1;
                    state      <= S_Y;
                end
                S_Y: begin
                    last_entry <= frame_addr[FRAME_AW-1:2] == '0;   // x of entry 0
                    frame_addr <= frame_addr - 1'b1;                // next attr
                    state      <= S_X;
                end
                S_X: state <= S_MAP;
                S_MAP: begin
                    if (drop_map) begin
                        state <= last_entry ? S_IDLE : S_FETCH;
                    end else begin
                        state <= S_ZONE;
                    end
                end
                S_ZONE: begin
                    if (accept_obj) begin
                        first <= 1'b0;
                        state <= S_CMD;
                    end else begin
                        state <= last_entry ? S_IDLE : S_FETCH;
                    end
                end
                S_CMD: begin
                    if (idle) begin   // back-pressure from renderer
                        cmd_start <= 1'b1;
                        state     <= S_CMD_END;
                    end
                end
                S_CMD_END: begin
                    cmd_start <= 1'b0;
                    if (n == attr_cols(obj_attr)) begin
                        state <= last_entry ? S_IDLE : S_FETCH;
                    end else begin
                        n     <= n + 4'd1;
                        npos  <= attr_hflip(obj_attr) ? npos - 4'd1 : npos + 4'd1;
                        state <= S_TILE_WAIT;
                    end
                end
                S_TILE_WAIT: state <= S_CMD;
                default: state <= S_IDLE;
            endcase
        end
    end

    // entry registers and command payload
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: if (start) vf <= vrender ^ {1'b0, {8{flip}}};
            S_ATTR: obj_attr <= frame_data;
            S_CODE: begin
                pre_code <= frame_data;
                cin      <= frame_data[15:6];
            end
            S_Y: obj_y <= frame_data[8:0];
            S_X: obj_x <= frame_data[8:0];
            S_MAP: obj_code <= {(pre_code[15:12] & res.mask) | res.offset, pre_code[11:0]};
            S_ZONE: begin
                if (accept_obj) begin
                    last_attr <= obj_attr;
                    last_code <= pre_code;
                    last_y    <= obj_y;
                    last_x    <= obj_x;
                end
            end
            S_CMD: begin
                if (idle) begin
                    cmd.code <= code_mn;
                    cmd.attr <= {4'd0, vsub, obj_attr[7:0]};
                    cmd.hpos <= eff_x - 9'd1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* hdl/obj_tile_match.sv */
// object vertical zone match
module obj_tile_match import obj_pkg::*; (
    input  logic      clk,
    input  obj_code_t code,      // mapped code
    input  obj_attr_t attr,
    input  tile_idx_t n,         // tile counter
    input  obj_vpos_t vf,        // line, flip applied
    input  obj_vpos_t y,
    output tile_idx_t vsub,
    output logic      inzone,
    output obj_code_t code_mn
);

    tile_idx_t m;
    logic      vflip;
    obj_vpos_t d;         // line relative to object top
    obj_vpos_t height;    // object height in lines
    tile_idx_t row;
    tile_idx_t row_eff;

    assign m     = attr_rows(attr);
    assign vflip = attr_vflip(attr);

    assign d      = vf - y;                     // wraps at 512
    assign height = {1'b0, m, 4'd0} + 9'd16;    // 16 * (m + 1), max 256

    // row only meaningful inside the zone
    assign row     = d[7:4];
    assign row_eff = vflip ? m - row : row;     // bottom row first

    always_ff @(posedge clk) begin
        inzone  <= d < height;
        vsub    <= d[3:0] ^ {4{vflip}};
        code_mn <= {code[15:8], code[7:4] + row_eff, code[3:0] + n};
    end

endmodule

/* hdl/gfx_bank_mapper.sv */
// graphics bank mapper
module gfx_bank_mapper import rom_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bank_cfg_t  bank,
    input  logic [9:0] cin,    // upper code bits
    output map_res_t   res
);

    logic [1:0] nib_idx;      // which nibble of offset/mask
    bank_nib_t  code_range;   // highest top nibble the game maps
    bank_nib_t  top_nib;
    logic       out_of_range;

    assign nib_idx    = bank.game[1:0];
    assign code_range = bank.game[5:2];
    assign top_nib    = cin[9:6];   // lower bits only matter for layer decode

    // zero range means every code maps
    assign out_of_range = (code_range != 4'd0) && (top_nib > code_range);

    // answer one cycle after cin
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res <= '0;
        end else begin
            res.offset   <= bank.offset[nib_idx];
            res.mask     <= bank.mask[nib_idx];
            res.unmapped <= out_of_range;
        end
    end

endmodule

/* hdl/obj_frame_ram.sv */
// object frame table
module obj_frame_ram import obj_pkg::*; #(
    parameter int FRAME_AW = 10
) (
    input  logic                clk,
    // cpu side, written during vblank
    input  logic                we,
    input  logic [FRAME_AW-1:0] waddr,
    input  obj_word_t           wdata,
    // scanner side
    input  logic [FRAME_AW-1:0] raddr,
    output obj_word_t           rdata
);

    // x, y, code, attr per entry
    obj_word_t mem [2**FRAME_AW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, one cycle
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* hdl/rom_pkg.sv */
// graphics ROM bank types
package rom_pkg;

    typedef logic [5:0] game_id_t;    // 5..2 code range, 1..0 nibble index
    typedef logic [3:0] bank_nib_t;   // one bank nibble

    // four nibbles, selected by game index
    typedef bank_nib_t [3:0] bank_set_t;

    typedef struct packed {
        game_id_t  game;
        bank_set_t offset;
        bank_set_t mask;
    } bank_cfg_t;

    // mapper answer for one tile code
    typedef struct packed {
        bank_nib_t offset;
        bank_nib_t mask;
        logic      unmapped;
    } map_res_t;

endpackage

/* hdl/obj_pkg.sv */
// object scanner types
package obj_pkg;

    typedef logic [15:0] obj_word_t;   // one frame table word
    typedef logic [15:0] obj_code_t;   // tile code
    typedef logic [15:0] obj_attr_t;   // m, n, flips and palette
    typedef logic [8:0]  obj_hpos_t;   // horizontal position
    typedef logic [8:0]  obj_vpos_t;   // line number
    typedef logic [3:0]  tile_idx_t;   // tile index or in-tile row

    // attribute fields
    function automatic tile_idx_t attr_rows(obj_attr_t a);
        return a[15:12];   // rows minus one
    endfunction

    function automatic tile_idx_t attr_cols(obj_attr_t a);
        return a[11:8];    // columns minus one
    endfunction

    function automatic logic attr_vflip(obj_attr_t a);
        return a[6];
    endfunction

    function automatic logic attr_hflip(obj_attr_t a);
        return a[5];
    endfunction

    function automatic logic [4:0] attr_pal(obj_attr_t a);
        return a[4:0];
    endfunction

    // scanner to renderer, attr carries in-tile row in 11..8
    typedef struct packed {
        obj_code_t code;
        obj_attr_t attr;
        obj_hpos_t hpos;   // left edge minus one
    } obj_cmd_t;

    // renderer output record
    typedef struct packed {
        obj_code_t  code;
        tile_idx_t  vsub;
        logic       hflip;
        logic [4:0] pal;
        obj_hpos_t  hpos;  // true left edge
    } obj_draw_t;

endpackage
